//--- turfctl_pkg.sv
package turfctl_pkg;

    // Bus widths
    localparam int ADR_W = 6;
    localparam int DAT_W = 32;
    localparam int SEL_W = 4;

    // Register map
    localparam logic [ADR_W-1:0] ADR_CTRL     = 6'h00;
    localparam logic [ADR_W-1:0] ADR_LINK_ERR = 6'h08;
    localparam logic [ADR_W-1:0] ADR_XFER_ERR = 6'h1C;

    // Timed error counters
    localparam int INTERVAL_W = 24;
    localparam int COUNT_W    = 25;

    // Phase adjust, 56 fine steps per period times 8
    localparam int              PS_W           = 9;
    localparam logic [PS_W-1:0] PS_MAX_DEFAULT = 9'd447;

    ////////////////////////////////////////////////////////////////////////////
    // Register 0 fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int CTRL_MMCM_RST    = 0;
    localparam int CTRL_MMCM_LOCKED = 1;
    localparam int CTRL_TRAIN       = 10;
    localparam int CTRL_PS_LSB      = 16;
    localparam int CTRL_PS_BUSY     = 31;

    // Bus transfer sequencing
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACK      = 2'd1,
        WAIT_SYS = 2'd2,
        REPLY    = 2'd3
    } fsm_state_t;

endpackage

//--- flag_sync.sv
`timescale 1ns/1ps

module flag_sync (
    input  logic clk_a_i,
    input  logic clk_b_i,
    input  logic flag_a_i,
    output logic flag_b_o
);

    // Each flag in domain A flips the level
    logic       toggle_a = 1'b0;

    // Stages 0 and 1 resynchronize, stage 2 keeps the previous level
    logic [2:0] sync_b = 3'b000;

    always_ff @(posedge clk_a_i) begin
        toggle_a <= toggle_a ^ flag_a_i;
    end

    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    // One level change is one flag in domain B
    assign flag_b_o = sync_b[2] ^ sync_b[1];

endmodule

//--- wb_access_fsm.sv
`timescale 1ns/1ps

module wb_access_fsm (
    input  logic                          wb_clk_i,
    input  logic                          wb_rst_i,
    input  logic                          sys_clk_i,
    input  logic                          sys_ok_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic [turfctl_pkg::ADR_W-1:0] wb_adr_i,
    output logic                          wb_ack_o,
    output logic                          load_dat_o,
    output logic                          sys_fault_o,
    output logic                          wr_commit_o,
    output logic                          sys_req_o
);

    import turfctl_pkg::*;

    fsm_state_t state_q;
    fsm_state_t state_d;
    logic       sys_access;
    logic       req_sent_q;
    logic       req_flag;
    logic       echo_sys = 1'b0;
    logic       echo_wb;

    // Both counters live in sys_clk_i
    assign sys_access = (wb_adr_i == ADR_LINK_ERR) || (wb_adr_i == ADR_XFER_ERR);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (wb_cyc_i && wb_stb_i) begin
                    state_d = sys_access ? WAIT_SYS : ACK;
                end
            end
            WAIT_SYS: begin
                if (!sys_ok_i || echo_wb) begin
                    state_d = REPLY;
                end
            end
            REPLY:   state_d = ACK;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q    <= IDLE;
            req_sent_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            req_sent_q <= (state_q == WAIT_SYS);
        end
    end

    // Request goes out on the first WAIT_SYS cycle only
    assign req_flag = (state_q == WAIT_SYS) && !req_sent_q && sys_ok_i;

    flag_sync u_req_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (sys_clk_i),
        .flag_a_i (req_flag),
        .flag_b_o (sys_req_o)
    );

    // sys_clk_i side answers every request one cycle later
    always_ff @(posedge sys_clk_i) begin
        echo_sys <= sys_req_o;
    end

    flag_sync u_echo_sync (
        .clk_a_i  (sys_clk_i),
        .clk_b_i  (wb_clk_i),
        .flag_a_i (echo_sys),
        .flag_b_o (echo_wb)
    );

    assign sys_fault_o = (state_q == WAIT_SYS) && !sys_ok_i;
    assign load_dat_o  = (state_q == WAIT_SYS) && (!sys_ok_i || echo_wb);
    assign wb_ack_o    = (state_q == ACK);
    assign wr_commit_o = (state_q == ACK);

endmodule

//--- timed_error_counter.sv
`timescale 1ns/1ps

module timed_error_counter #(
    parameter logic [turfctl_pkg::ADR_W-1:0] COUNTER_ADDR = turfctl_pkg::ADR_LINK_ERR
) (
    input  logic                               wb_clk_i,
    input  logic                               wb_rst_i,
    input  logic                               sys_clk_i,
    input  logic                               err_i,
    input  logic                               sys_req_i,
    input  logic [turfctl_pkg::ADR_W-1:0]      adr_i,
    input  logic                               we_i,
    input  logic [turfctl_pkg::INTERVAL_W-1:0] interval_i,
    output logic [turfctl_pkg::COUNT_W-1:0]    count_o
);

    import turfctl_pkg::*;

    // Window starts at the longest interval until one is written
    logic [INTERVAL_W-1:0] interval_q  = '1;
    logic [INTERVAL_W-1:0] timer_q     = '0;
    logic [COUNT_W-1:0]    acc_q       = '0;
    logic [COUNT_W-1:0]    result_q    = '0;
    logic                  hold_q      = 1'b0;
    logic                  count_valid = 1'b0;
    logic [COUNT_W-1:0]    acc_next;
    logic                  load;
    logic                  valid_wb;
    logic                  ack_sys;

    assign load     = sys_req_i && we_i && (adr_i == COUNTER_ADDR);
    assign acc_next = acc_q + COUNT_W'(err_i);

    ////////////////////////////////////////////////////////////////////////////
    // sys_clk_i window
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk_i) begin
        count_valid <= 1'b0;
        if (load) begin
            interval_q <= interval_i;
            timer_q    <= '0;
            acc_q      <= '0;
            hold_q     <= 1'b0;
        end else if (hold_q) begin
            // Result stays put until wb_clk_i has taken it
            if (ack_sys) begin
                timer_q <= '0;
                acc_q   <= '0;
                hold_q  <= 1'b0;
            end
        end else if (timer_q == interval_q - 1'b1) begin
            result_q    <= acc_next;
            count_valid <= 1'b1;
            hold_q      <= 1'b1;
        end else begin
            timer_q <= timer_q + 1'b1;
            acc_q   <= acc_next;
        end
    end

    flag_sync u_valid_sync (
        .clk_a_i  (sys_clk_i),
        .clk_b_i  (wb_clk_i),
        .flag_a_i (count_valid),
        .flag_b_o (valid_wb)
    );

    // Same flag goes back as the restart acknowledge
    flag_sync u_ack_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (sys_clk_i),
        .flag_a_i (valid_wb),
        .flag_b_o (ack_sys)
    );

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            count_o <= '0;
        end else if (valid_wb) begin
            count_o <= result_q;
        end
    end

endmodule

//--- phase_shift_stepper.sv
`timescale 1ns/1ps

module phase_shift_stepper #(
    parameter logic [turfctl_pkg::PS_W-1:0] PS_MAX = turfctl_pkg::PS_MAX_DEFAULT
) (
    input  logic                         wb_clk_i,
    input  logic                         wb_rst_i,
    input  logic [turfctl_pkg::PS_W-1:0] target_i,
    input  logic                         ps_done_i,
    output logic                         ps_en_o,
    output logic                         busy_o
);

    import turfctl_pkg::*;

    logic [PS_W-1:0] current_q;
    logic [PS_W-1:0] current_next;
    logic            waiting_q;
    logic            busy_q;
    logic            mismatch;

    assign mismatch = (current_q != target_i);

    // Phase only moves forward and wraps past the last fine step
    assign current_next = (current_q == PS_MAX) ? '0 : current_q + 1'b1;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            current_q <= '0;
            ps_en_o   <= 1'b0;
            waiting_q <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            ps_en_o <= mismatch && !waiting_q && !ps_en_o;
            if (ps_en_o) begin
                current_q <= current_next;
                waiting_q <= 1'b1;
            end else if (ps_done_i) begin
                waiting_q <= 1'b0;
            end
            // Drops the cycle after the final done
            busy_q <= mismatch || ps_en_o || (waiting_q && !ps_done_i);
        end
    end

    assign busy_o = busy_q;

endmodule

//--- turfctl_regs.sv
`timescale 1ns/1ps

module turfctl_regs (
    input  logic                               wb_clk_i,
    input  logic                               wb_rst_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [turfctl_pkg::ADR_W-1:0]      wb_adr_i,
    input  logic [turfctl_pkg::SEL_W-1:0]      wb_sel_i,
    input  logic [turfctl_pkg::DAT_W-1:0]      wb_dat_i,
    input  logic                               wr_commit_i,
    input  logic                               load_dat_i,
    input  logic                               sys_fault_i,
    input  logic                               mmcm_locked_i,
    input  logic                               ps_busy_i,
    input  logic [turfctl_pkg::COUNT_W-1:0]    link_count_i,
    input  logic [turfctl_pkg::COUNT_W-1:0]    xfer_count_i,
    output logic [turfctl_pkg::DAT_W-1:0]      wb_dat_o,
    output logic [turfctl_pkg::ADR_W-1:0]      adr_o,
    output logic                               we_o,
    output logic [turfctl_pkg::INTERVAL_W-1:0] interval_o,
    output logic [turfctl_pkg::PS_W-1:0]       ps_target_o,
    output logic                               mmcm_rst_o,
    output logic                               train_o
);

    import turfctl_pkg::*;

    logic [DAT_W-1:0]   dat_q;
    logic [ADR_W-1:0]   adr_q;
    logic [SEL_W-1:0]   sel_q;
    logic               we_q;
    logic               mmcm_rst_q;
    logic               train_q;
    logic [PS_W-1:0]    ps_target_q;
    logic [DAT_W-1:0]   ctrl_word;
    logic [DAT_W-1:0]   rd_q;
    logic [COUNT_W-1:0] count_sel;
    logic               ctrl_write;

    ////////////////////////////////////////////////////////////////////////////
    // Request latch
    ////////////////////////////////////////////////////////////////////////////

    // Held steady for the whole sys_clk_i round trip
    always_ff @(posedge wb_clk_i) begin
        if (wb_cyc_i && wb_stb_i) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (wb_sel_i[i]) begin
                    dat_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
            adr_q <= wb_adr_i;
            we_q  <= wb_we_i;
            sel_q <= wb_sel_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register 0
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl_write = wr_commit_i && we_q && (adr_q == ADR_CTRL);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            mmcm_rst_q  <= 1'b0;
            train_q     <= 1'b0;
            ps_target_q <= '0;
        end else if (ctrl_write) begin
            if (sel_q[0]) begin
                mmcm_rst_q <= dat_q[CTRL_MMCM_RST];
            end
            if (sel_q[1]) begin
                train_q <= dat_q[CTRL_TRAIN];
            end
            // Phase target straddles lanes 2 and 3
            if (sel_q[2]) begin
                ps_target_q[7:0] <= dat_q[CTRL_PS_LSB +: 8];
            end
            if (sel_q[3]) begin
                ps_target_q[PS_W-1] <= dat_q[CTRL_PS_LSB + PS_W - 1];
            end
        end
    end

    always_comb begin
        ctrl_word                        = '0;
        ctrl_word[CTRL_MMCM_RST]         = mmcm_rst_q;
        ctrl_word[CTRL_MMCM_LOCKED]      = mmcm_locked_i;
        ctrl_word[CTRL_TRAIN]            = train_q;
        ctrl_word[CTRL_PS_LSB +: PS_W]   = ps_target_q;
        ctrl_word[CTRL_PS_BUSY]          = ps_busy_i;
    end

    // Read data
    assign count_sel = (adr_q == ADR_XFER_ERR) ? xfer_count_i : link_count_i;

    always_ff @(posedge wb_clk_i) begin
        if (load_dat_i) begin
            rd_q <= sys_fault_i ? '1 : DAT_W'(count_sel);
        end else if (wb_cyc_i && wb_stb_i && !wb_we_i && (wb_adr_i == ADR_CTRL)) begin
            rd_q <= ctrl_word;
        end
    end

    assign wb_dat_o    = rd_q;
    assign adr_o       = adr_q;
    assign we_o        = we_q;
    assign interval_o  = dat_q[INTERVAL_W-1:0];
    assign ps_target_o = ps_target_q;
    assign mmcm_rst_o  = mmcm_rst_q;
    assign train_o     = train_q;

endmodule

//--- turfctl_register_core.sv
`timescale 1ns/1ps

module turfctl_register_core #(
    parameter logic [turfctl_pkg::PS_W-1:0] PS_MAX = turfctl_pkg::PS_MAX_DEFAULT
) (
    input  logic                          wb_clk_i,
    input  logic                          wb_rst_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [turfctl_pkg::ADR_W-1:0] wb_adr_i,
    input  logic [turfctl_pkg::SEL_W-1:0] wb_sel_i,
    input  logic [turfctl_pkg::DAT_W-1:0] wb_dat_i,
    output logic                          wb_ack_o,
    output logic [turfctl_pkg::DAT_W-1:0] wb_dat_o,
    input  logic                          sys_clk_i,
    input  logic                          sys_ok_i,
    input  logic                          mmcm_locked_i,
    input  logic                          link_err_i,
    input  logic                          xfer_err_i,
    input  logic                          ps_done_i,
    output logic                          ps_en_o,
    output logic                          mmcm_rst_o,
    output logic                          train_o
);

    import turfctl_pkg::*;

    logic                  load_dat;
    logic                  sys_fault;
    logic                  wr_commit;
    logic                  sys_req;
    logic [ADR_W-1:0]      req_adr;
    logic                  req_we;
    logic [INTERVAL_W-1:0] interval;
    logic [PS_W-1:0]       ps_target;
    logic                  ps_busy;
    logic [COUNT_W-1:0]    link_count;
    logic [COUNT_W-1:0]    xfer_count;

    wb_access_fsm u_access_fsm (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .sys_clk_i   (sys_clk_i),
        .sys_ok_i    (sys_ok_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_adr_i    (wb_adr_i),
        .wb_ack_o    (wb_ack_o),
        .load_dat_o  (load_dat),
        .sys_fault_o (sys_fault),
        .wr_commit_o (wr_commit),
        .sys_req_o   (sys_req)
    );

    // Link error counter at 0x08
    timed_error_counter #(.COUNTER_ADDR(ADR_LINK_ERR)) u_link_err (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .sys_clk_i  (sys_clk_i),
        .err_i      (link_err_i),
        .sys_req_i  (sys_req),
        .adr_i      (req_adr),
        .we_i       (req_we),
        .interval_i (interval),
        .count_o    (link_count)
    );

    // Clock-transfer error counter at 0x1C
    timed_error_counter #(.COUNTER_ADDR(ADR_XFER_ERR)) u_xfer_err (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .sys_clk_i  (sys_clk_i),
        .err_i      (xfer_err_i),
        .sys_req_i  (sys_req),
        .adr_i      (req_adr),
        .we_i       (req_we),
        .interval_i (interval),
        .count_o    (xfer_count)
    );

    phase_shift_stepper #(.PS_MAX(PS_MAX)) u_stepper (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .target_i  (ps_target),
        .ps_done_i (ps_done_i),
        .ps_en_o   (ps_en_o),
        .busy_o    (ps_busy)
    );

    turfctl_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_i      (wb_dat_i),
        .wr_commit_i   (wr_commit),
        .load_dat_i    (load_dat),
        .sys_fault_i   (sys_fault),
        .mmcm_locked_i (mmcm_locked_i),
        .ps_busy_i     (ps_busy),
        .link_count_i  (link_count),
        .xfer_count_i  (xfer_count),
        .wb_dat_o      (wb_dat_o),
        .adr_o         (req_adr),
        .we_o          (req_we),
        .interval_o    (interval),
        .ps_target_o   (ps_target),
        .mmcm_rst_o    (mmcm_rst_o),
        .train_o       (train_o)
    );

endmodule

//--- turfctl_assert.sv
`timescale 1ns/1ps

module turfctl_assert (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    cyc_i,
    input logic                    stb_i,
    input logic                    ack_i,
    input logic                    ps_en_i,
    input logic                    ps_done_i,
    input turfctl_pkg::fsm_state_t state_i
);

    import turfctl_pkg::*;

    // Set by a step, cleared by its done
    logic step_pending;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            step_pending <= 1'b0;
        end else if (ps_en_i) begin
            step_pending <= 1'b1;
        end else if (ps_done_i) begin
            step_pending <= 1'b0;
        end
    end

    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else $error("wb_ack_o high in two cycles in a row");

    a_ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> (cyc_i && stb_i && $past(cyc_i && stb_i)))
        else $error("wb_ack_o without a held cyc and stb");

    // The master holds its request until the transfer ends
    a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i != IDLE) |-> (cyc_i && stb_i))
        else $error("Transfer in progress without cyc and stb");

    a_step_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        step_pending |-> !ps_en_i)
        else $error("ps_en_o while a step still waits for ps_done_i");

endmodule

bind turfctl_register_core turfctl_assert u_assert (
    .clk_i     (wb_clk_i),
    .rst_i     (wb_rst_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .ack_i     (wb_ack_o),
    .ps_en_i   (ps_en_o),
    .ps_done_i (ps_done_i),
    .state_i   (u_access_fsm.state_q)
);

//--- tb_turfctl.sv
`timescale 1ns/1ps

module tb_turfctl;

    import turfctl_pkg::*;

    localparam logic [PS_W-1:0] PS_MAX     = 9'd447;
    localparam int              PS_STEPS   = 448;
    localparam logic [31:0]     SEED       = 32'h3e69_9726;
    localparam int              POLL_LIMIT = 4000;
    // Three phase runs of at most 447 steps at up to 7 cycles each, plus counter windows
    localparam int              TIMEOUT_CYCLES = 20000;

    logic                  wb_clk_i;
    logic                  wb_rst_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [ADR_W-1:0]      wb_adr_i;
    logic [SEL_W-1:0]      wb_sel_i;
    logic [DAT_W-1:0]      wb_dat_i;
    logic                  wb_ack_o;
    logic [DAT_W-1:0]      wb_dat_o;
    logic                  sys_clk_i;
    logic                  sys_ok_i;
    logic                  mmcm_locked_i;
    logic                  link_err_i;
    logic                  xfer_err_i;
    logic                  ps_done_i;
    logic                  ps_en_o;
    logic                  mmcm_rst_o;
    logic                  train_o;

    logic [31:0]           rng_state;
    int                    step_delay;
    int                    pulse_count;
    int                    cycle_count;
    int                    error_count;
    int                    check_count;
    int                    test_count;
    int                    failed_tests;
    int                    test_start_errors;

    // Register 0 model
    logic                  m_rst;
    logic                  m_locked;
    logic                  m_train;
    logic [PS_W-1:0]       m_target;
    logic [PS_W-1:0]       m_phase;

    turfctl_register_core #(.PS_MAX(PS_MAX)) dut (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .sys_clk_i     (sys_clk_i),
        .sys_ok_i      (sys_ok_i),
        .mmcm_locked_i (mmcm_locked_i),
        .link_err_i    (link_err_i),
        .xfer_err_i    (xfer_err_i),
        .ps_done_i     (ps_done_i),
        .ps_en_o       (ps_en_o),
        .mmcm_rst_o    (mmcm_rst_o),
        .train_o       (train_o)
    );

    always #2 wb_clk_i = ~wb_clk_i;
    always #3 sys_clk_i = ~sys_clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] expected_ctrl(input logic rst, input logic locked,
                                                  input logic train, input logic [8:0] target,
                                                  input logic busy);
        logic [31:0] word;
        word     = 32'h0;
        word[0]  = rst;
        word[1]  = locked;
        word[10] = train;
        word[24:16] = target;
        word[31] = busy;
        return word;
    endfunction

    // A window with the error line held high counts every cycle of it
    function automatic logic [31:0] expected_count(input logic [23:0] interval,
                                                   input logic err_level, input logic ok);
        if (!ok) begin
            return 32'hFFFF_FFFF;
        end
        return err_level ? {8'h00, interval} : 32'h0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
        test_count++;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_start_errors) begin
            $display("test %0d (%s): ok", test_count, name);
        end else begin
            $display("test %0d (%s): %0d errors", test_count, name,
                     error_count - test_start_errors);
            failed_tests++;
        end
    endtask

    task automatic bus_transfer(input logic we, input logic [ADR_W-1:0] adr,
                                input logic [31:0] dat, input logic [3:0] sel,
                                output logic [31:0] rdata);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        @(negedge wb_clk_i);
        while (!wb_ack_o) begin
            @(negedge wb_clk_i);
        end
        rdata = wb_dat_o;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_transfer(1'b1, adr, dat, sel, unused);
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [31:0] rdata);
        bus_transfer(1'b0, adr, 32'h0, 4'hF, rdata);
    endtask

    task automatic check_ctrl_state();
        logic [31:0] rdata;
        @(negedge wb_clk_i);
        check_value("mmcm_rst_o", {31'b0, mmcm_rst_o}, {31'b0, m_rst});
        check_value("train_o", {31'b0, train_o}, {31'b0, m_train});
        bus_read(ADR_CTRL, rdata);
        check_value("wb_dat_o", rdata, expected_ctrl(m_rst, m_locked, m_train, m_target, 1'b0));
    endtask

    task automatic set_error_line(input logic [ADR_W-1:0] adr, input logic level);
        @(posedge wb_clk_i);
        if (adr == ADR_XFER_ERR) begin
            xfer_err_i <= level;
        end else begin
            link_err_i <= level;
        end
    endtask

    // Reads until the masked value equals (or leaves) the reference
    task automatic poll_register(input logic [ADR_W-1:0] adr, input logic [31:0] mask,
                                 input logic [31:0] ref_value, input logic until_equal,
                                 output logic [31:0] value);
        int  polls;
        logic done;
        polls = 0;
        done  = 1'b0;
        check_count++;
        while (!done && polls < POLL_LIMIT) begin
            bus_read(adr, value);
            done = until_equal ? ((value & mask) == ref_value) : ((value & mask) != ref_value);
            polls++;
        end
        if (!done) begin
            $display("Register %h never reached the awaited value after %0d reads", adr, polls);
            error_count++;
        end
    endtask

    // Phase-shift primitive, answers each step after a short random delay
    always begin
        @(negedge wb_clk_i);
        if (ps_en_o) begin
            pulse_count++;
            rng_state  = xorshift32(rng_state);
            step_delay = int'(rng_state % 4);
            repeat (step_delay) @(posedge wb_clk_i);
            @(posedge wb_clk_i);
            ps_done_i <= 1'b1;
            @(posedge wb_clk_i);
            ps_done_i <= 1'b0;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge wb_clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d wb_clk_i cycles, the tests did not finish", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_counter(input logic [ADR_W-1:0] adr, input logic [23:0] n);
        logic [31:0] rdata;
        start_test();
        set_error_line(adr, 1'b1);
        bus_write(adr, {8'h00, n}, 4'hF);
        poll_register(adr, 32'hFFFF_FFFF, 32'h0, 1'b0, rdata);
        check_value("wb_dat_o", rdata, expected_count(n, 1'b1, 1'b1));
        set_error_line(adr, 1'b0);
        poll_register(adr, 32'hFFFF_FFFF, expected_count(n, 1'b0, 1'b1), 1'b1, rdata);
        finish_test(adr == ADR_XFER_ERR ? "transfer error counter" : "link error counter");
    endtask

    initial begin
        logic [31:0]     rdata;
        logic [PS_W-1:0] target;
        int              expected_pulses;
        wb_clk_i      = 1'b0;
        sys_clk_i     = 1'b0;
        wb_rst_i      = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_sel_i      = '0;
        wb_dat_i      = '0;
        sys_ok_i      = 1'b1;
        mmcm_locked_i = 1'b1;
        link_err_i    = 1'b0;
        xfer_err_i    = 1'b0;
        ps_done_i     = 1'b0;
        rng_state     = SEED;
        pulse_count   = 0;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        m_rst         = 1'b0;
        m_locked      = 1'b1;
        m_train       = 1'b0;
        m_target      = '0;
        m_phase       = '0;
        repeat (3) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;

        start_test();
        @(negedge wb_clk_i);
        check_value("ps_en_o", {31'b0, ps_en_o}, 32'h0);
        check_ctrl_state();
        // Bit 1 follows the MMCM lock input
        @(posedge wb_clk_i);
        mmcm_locked_i <= 1'b0;
        m_locked = 1'b0;
        check_ctrl_state();
        @(posedge wb_clk_i);
        mmcm_locked_i <= 1'b1;
        m_locked = 1'b1;
        finish_test("reset values");

        // Lane 0 holds the MMCM reset, lane 1 the train enable
        start_test();
        bus_write(ADR_CTRL, 32'h0000_0401, 4'b0011);
        m_rst   = 1'b1;
        m_train = 1'b1;
        check_ctrl_state();
        bus_write(ADR_CTRL, 32'h0000_0000, 4'b0010);
        m_train = 1'b0;
        check_ctrl_state();
        bus_write(ADR_CTRL, 32'h0000_0401, 4'b1100);
        check_ctrl_state();
        bus_write(ADR_CTRL, 32'h0000_0000, 4'b0001);
        m_rst = 1'b0;
        check_ctrl_state();
        finish_test("control fields and byte selects");

        start_test();
        for (int i = 0; i < 3; i++) begin
            rng_state       = xorshift32(rng_state);
            target          = 9'(rng_state % PS_STEPS);
            expected_pulses = (int'(target) - int'(m_phase) + PS_STEPS) % PS_STEPS;
            pulse_count     = 0;
            bus_write(ADR_CTRL, {7'b0, target, 16'h0}, 4'b1100);
            m_target = target;
            // Wait for the busy bit to drop
            poll_register(ADR_CTRL, 32'h8000_0000, 32'h0, 1'b1, rdata);
            bus_read(ADR_CTRL, rdata);
            check_value("ps_en_o pulses", pulse_count, expected_pulses);
            check_value("wb_dat_o", rdata,
                        expected_ctrl(m_rst, m_locked, m_train, target, 1'b0));
            m_phase = target;
        end
        finish_test("phase stepping");

        test_counter(ADR_LINK_ERR, 24'd40);
        test_counter(ADR_XFER_ERR, 24'd25);

        start_test();
        @(posedge wb_clk_i);
        sys_ok_i <= 1'b0;
        bus_read(ADR_LINK_ERR, rdata);
        check_value("wb_dat_o", rdata, expected_count(24'd40, 1'b0, 1'b0));
        bus_read(ADR_XFER_ERR, rdata);
        check_value("wb_dat_o", rdata, expected_count(24'd25, 1'b0, 1'b0));
        @(posedge wb_clk_i);
        sys_ok_i <= 1'b1;
        finish_test("counter access without sys_clk_i");

        repeat (4) @(posedge wb_clk_i);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
turfctl_pkg.sv
flag_sync.sv
wb_access_fsm.sv
timed_error_counter.sv
phase_shift_stepper.sv
turfctl_regs.sv
turfctl_register_core.sv
turfctl_assert.sv
tb_turfctl.sv

//--- Makefile
# Verilator build and run of the turfctl register block testbench

VERILATOR ?= verilator
TOP       ?= tb_turfctl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
